//--- source/seq_pkg.sv
package seq_pkg;

    ////////////////////
    // Widths with a meaning
    typedef logic [63:0] word_t;      // Register and memory word
    typedef logic [4:0]  reg_addr_t;  // General register index
    typedef logic [39:0] delay_t;     // Immediate and stall count
    typedef logic [15:0] offset_t;    // Tx and gradient offsets

    localparam int    NUM_REGS   = 32;
    localparam word_t PULSE_IDLE = 64'hFF00;  // Pulse word while idle

    ////////////////////
    // Instruction opcodes, top 6 bits of the word
    typedef enum logic [5:0] {
        DEC        = 6'b000001,  // ra <= ra - 1
        INC        = 6'b000010,  // ra <= ra + 1
        LD64       = 6'b000100,  // ra <= mem[addr]
        TXOFFSET   = 6'b001000,
        GRADOFFSET = 6'b001001,
        JNZ        = 6'b010000,  // Jump if ra nonzero
        J          = 6'b010111,
        HALT       = 6'b011001,
        NOP        = 6'b011010,  // Wait imm + 1 cycles
        PR         = 6'b011101   // Pulse from rb, then wait
    } opcode_e;

    typedef enum logic [7:0] {
        Valid         = 8'h00,
        InvalidOpcode = 8'h01,
        InvalidState  = 8'h02
    } error_code_e;

    typedef enum logic [3:0] {
        Reset, Fetch, WaitForFetch, WaitForFetch2, MemWait, Decode, Execute,
        Stall, MemAccess, MemAccess2, WriteBack, Halted
    } state_e;

    ////////////////////
    // Latched instruction fields
    typedef struct packed {
        opcode_e   op;
        reg_addr_t ra;
        reg_addr_t rb;
        delay_t    imm;
    } instr_t;

    // Command from the control FSM to the output registers
    typedef struct packed {
        logic  clear_idle;  // Back to idle values
        logic  arm;         // Zero the pulse at run start
        logic  tx_we;
        logic  grad_we;
        logic  pulse_we;
        word_t data;
    } out_cmd_t;

endpackage

//--- source/seq_regfile.sv
`timescale 1ns/1ns

module seq_regfile (
    input  logic               clk,
    input  logic               rst_n,
    input  seq_pkg::reg_addr_t rd_a_addr_i,
    input  seq_pkg::reg_addr_t rd_b_addr_i,
    input  logic               wr_en_i,
    input  seq_pkg::reg_addr_t wr_addr_i,
    input  seq_pkg::word_t     wr_data_i,
    output seq_pkg::word_t     rd_a_data_o,
    output seq_pkg::word_t     rd_b_data_o
);
    import seq_pkg::*;

    word_t regs [NUM_REGS];

    // Single write port
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en_i) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    // Two asynchronous read ports
    assign rd_a_data_o = regs[rd_a_addr_i];
    assign rd_b_data_o = regs[rd_b_addr_i];

endmodule

//--- source/seq_control.sv
`timescale 1ns/1ns

module seq_control #(
    parameter int PC_W = 10
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start_i,
    input  logic                 stop_i,
    output logic [PC_W-1:0]      mem_addr_o,
    input  seq_pkg::word_t       mem_rdata_i,
    output seq_pkg::reg_addr_t   rd_a_addr_o,
    output seq_pkg::reg_addr_t   rd_b_addr_o,
    input  seq_pkg::word_t       rd_a_data_i,
    input  seq_pkg::word_t       rd_b_data_i,
    output logic                 wr_en_o,
    output seq_pkg::reg_addr_t   wr_addr_o,
    output seq_pkg::word_t       wr_data_o,
    output seq_pkg::out_cmd_t    out_cmd_o,
    output logic                 interrupt_start_o,
    output logic                 interrupt_error_o,
    output logic                 active_o,
    output seq_pkg::error_code_e error_code_o
);
    import seq_pkg::*;

    state_e          state_q, state_d;
    logic [PC_W-1:0] pc_q, pc_d;
    logic [PC_W-1:0] next_pc_q, next_pc_d;
    logic [PC_W-1:0] mem_addr_q, mem_addr_d;
    instr_t          instr_q, instr_d;
    word_t           op_a_q, op_a_d;
    word_t           op_b_q, op_b_d;
    word_t           result_q, result_d;
    delay_t          stall_q, stall_d;
    error_code_e     error_q, error_d;
    logic            start_seq;
    logic [PC_W-1:0] direct_addr;

    assign direct_addr  = instr_q.imm[PC_W-1:0];  // Format A direct address
    assign mem_addr_o   = mem_addr_q;
    assign error_code_o = error_q;
    assign active_o     = (state_q != Reset) && (state_q != Halted);
    assign start_seq    = (state_q == Reset) && start_i && !stop_i;

    // Register file addressing follows the latched instruction
    assign rd_a_addr_o = instr_q.ra;
    assign rd_b_addr_o = instr_q.rb;
    assign wr_addr_o   = instr_q.ra;

    ////////////////////
    // Control state
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q           <= Reset;
            pc_q              <= '0;
            mem_addr_q        <= '0;
            stall_q           <= '0;
            error_q           <= Valid;
            interrupt_start_o <= 1'b0;
            interrupt_error_o <= 1'b0;
        end else begin
            state_q           <= state_d;
            pc_q              <= pc_d;
            mem_addr_q        <= mem_addr_d;
            stall_q           <= stall_d;
            error_q           <= error_d;
            interrupt_start_o <= start_seq;
            interrupt_error_o <= (state_d == Halted) && (state_q != Halted);
        end
    end

    // Instruction and operand payload
    always_ff @(posedge clk) begin
        next_pc_q <= next_pc_d;
        instr_q   <= instr_d;
        op_a_q    <= op_a_d;
        op_b_q    <= op_b_d;
        result_q  <= result_d;
    end

    ////////////////////
    // Next state and datapath
    always_comb begin
        state_d    = state_q;
        pc_d       = pc_q;
        next_pc_d  = next_pc_q;
        mem_addr_d = mem_addr_q;
        instr_d    = instr_q;
        op_a_d     = op_a_q;
        op_b_d     = op_b_q;
        result_d   = result_q;
        stall_d    = stall_q;
        error_d    = error_q;
        wr_en_o    = 1'b0;
        wr_data_o  = result_q;
        out_cmd_o      = '0;
        out_cmd_o.data = result_q;

        if (stop_i) begin
            // Software stop overrides everything
            state_d              = Reset;
            out_cmd_o.clear_idle = 1'b1;
        end else begin
            case (state_q)
                Reset: begin
                    if (start_i) begin
                        state_d       = Fetch;
                        pc_d          = '0;
                        error_d       = Valid;
                        out_cmd_o.arm = 1'b1;
                    end else begin
                        out_cmd_o.clear_idle = 1'b1;  // Hold idle outputs
                    end
                end
                Fetch: begin
                    mem_addr_d = pc_q;
                    next_pc_d  = pc_q + 1'b1;
                    state_d    = WaitForFetch;
                end
                WaitForFetch: state_d = MemWait;
                MemWait:      state_d = WaitForFetch2;
                WaitForFetch2: begin
                    // Memory word is valid by now
                    instr_d.op  = opcode_e'(mem_rdata_i[63:58]);
                    instr_d.rb  = mem_rdata_i[44:40];
                    instr_d.ra  = mem_rdata_i[36:32];
                    instr_d.imm = mem_rdata_i[39:0];
                    state_d     = Decode;
                end
                Decode: begin
                    op_a_d  = rd_a_data_i;
                    op_b_d  = rd_b_data_i;
                    state_d = Execute;
                end
                Execute: begin
                    state_d = MemAccess;
                    case (instr_q.op)
                        DEC: result_d = op_a_q - 64'd1;
                        INC: result_d = op_a_q + 64'd1;
                        LD64: mem_addr_d = direct_addr;
                        TXOFFSET, GRADOFFSET: begin
                            result_d = word_t'(offset_t'(instr_q.imm));
                        end
                        JNZ: begin
                            result_d = '0;
                            result_d[PC_W-1:0] = (op_a_q != '0) ? direct_addr : next_pc_q;
                        end
                        J: begin
                            result_d = '0;
                            result_d[PC_W-1:0] = direct_addr;
                        end
                        NOP: begin
                            stall_d = instr_q.imm;
                            state_d = Stall;
                        end
                        PR: begin
                            out_cmd_o.pulse_we = 1'b1;
                            out_cmd_o.data     = op_b_q;  // Pulse from rb
                            stall_d            = instr_q.imm;
                            state_d            = Stall;
                        end
                        HALT: begin
                            state_d = Halted;
                            error_d = Valid;
                        end
                        default: begin
                            state_d = Halted;
                            error_d = InvalidOpcode;
                        end
                    endcase
                end
                Stall: begin
                    if (stall_q == '0) begin
                        state_d = MemAccess;
                    end else begin
                        stall_d = stall_q - 1'b1;
                    end
                end
                MemAccess: begin
                    pc_d    = next_pc_q;
                    state_d = MemAccess2;
                end
                MemAccess2: state_d = WriteBack;
                WriteBack: begin
                    state_d = Fetch;
                    case (instr_q.op)
                        LD64: begin
                            wr_en_o   = 1'b1;
                            wr_data_o = mem_rdata_i;
                        end
                        DEC, INC:   wr_en_o = 1'b1;
                        TXOFFSET:   out_cmd_o.tx_we = 1'b1;
                        GRADOFFSET: out_cmd_o.grad_we = 1'b1;
                        JNZ, J:     pc_d = result_q[PC_W-1:0];  // Branch target
                        default: ;
                    endcase
                end
                Halted: state_d = Halted;  // Wait for stop
                default: begin
                    state_d = Halted;
                    error_d = InvalidState;
                end
            endcase
        end
    end

endmodule

//--- source/seq_out_regs.sv
`timescale 1ns/1ns

module seq_out_regs (
    input  logic              clk,
    input  logic              rst_n,
    input  seq_pkg::out_cmd_t cmd_i,
    output seq_pkg::offset_t  tx_offset_o,
    output seq_pkg::offset_t  grad_offset_o,
    output seq_pkg::word_t    pulse_o
);
    import seq_pkg::*;

    offset_t offset_data;

    assign offset_data = cmd_i.data[$bits(offset_t)-1:0];  // Low bits of the command word

    ////////////////////
    // Priority: idle, arm, then the write enables
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tx_offset_o   <= '0;
            grad_offset_o <= '0;
            pulse_o       <= PULSE_IDLE;
        end else if (cmd_i.clear_idle) begin
            tx_offset_o   <= '0;
            grad_offset_o <= '0;
            pulse_o       <= PULSE_IDLE;
        end else if (cmd_i.arm) begin
            pulse_o       <= '0;  // Run starts with pulse cleared
        end else begin
            if (cmd_i.tx_we) begin
                tx_offset_o <= offset_data;
            end
            if (cmd_i.grad_we) begin
                grad_offset_o <= offset_data;
            end
            if (cmd_i.pulse_we) begin
                pulse_o <= cmd_i.data;
            end
        end
    end

endmodule

//--- source/seq_top.sv
`timescale 1ns/1ns

module seq_top #(
    parameter int PC_W = 10
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start_i,
    input  logic                 stop_i,
    output logic [PC_W-1:0]      mem_addr_o,
    input  seq_pkg::word_t       mem_rdata_i,
    output seq_pkg::offset_t     tx_offset_o,
    output seq_pkg::offset_t     grad_offset_o,
    output seq_pkg::word_t       pulse_o,
    output logic                 interrupt_start_o,
    output logic                 interrupt_error_o,
    output seq_pkg::error_code_e error_code_o,
    output logic                 active_o
);
    import seq_pkg::*;

    ////////////////////
    // Register file port
    reg_addr_t rd_a_addr;
    reg_addr_t rd_b_addr;
    reg_addr_t wr_addr;
    word_t     rd_a_data;
    word_t     rd_b_data;
    word_t     wr_data;
    logic      wr_en;

    out_cmd_t  out_cmd;  // FSM to output registers

    seq_control #(
        .PC_W (PC_W)
    ) u_control (
        .clk               (clk),
        .rst_n             (rst_n),
        .start_i           (start_i),
        .stop_i            (stop_i),
        .mem_addr_o        (mem_addr_o),
        .mem_rdata_i       (mem_rdata_i),
        .rd_a_addr_o       (rd_a_addr),
        .rd_b_addr_o       (rd_b_addr),
        .rd_a_data_i       (rd_a_data),
        .rd_b_data_i       (rd_b_data),
        .wr_en_o           (wr_en),
        .wr_addr_o         (wr_addr),
        .wr_data_o         (wr_data),
        .out_cmd_o         (out_cmd),
        .interrupt_start_o (interrupt_start_o),
        .interrupt_error_o (interrupt_error_o),
        .active_o          (active_o),
        .error_code_o      (error_code_o)
    );

    seq_regfile u_regfile (
        .clk         (clk),
        .rst_n       (rst_n),
        .rd_a_addr_i (rd_a_addr),
        .rd_b_addr_i (rd_b_addr),
        .wr_en_i     (wr_en),
        .wr_addr_i   (wr_addr),
        .wr_data_i   (wr_data),
        .rd_a_data_o (rd_a_data),
        .rd_b_data_o (rd_b_data)
    );

    seq_out_regs u_out_regs (
        .clk           (clk),
        .rst_n         (rst_n),
        .cmd_i         (out_cmd),
        .tx_offset_o   (tx_offset_o),
        .grad_offset_o (grad_offset_o),
        .pulse_o       (pulse_o)
    );

endmodule

//--- testbench/tb_clock.sv
`timescale 1ns/1ns

module tb_clock #(
    parameter int PERIOD_NS = 100
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
    end

    // Free running, half period high
    always begin
        #(PERIOD_NS / 2);
        clk_o = ~clk_o;
    end

endmodule

//--- testbench/seq_assert.sv
`timescale 1ns/1ns

module seq_assert (
    input logic            clk,
    input logic            rst_n,
    input logic            stop_i,
    input seq_pkg::state_e state_i,
    input logic            active_i,
    input logic            irq_start_i,
    input logic            irq_error_i
);
    import seq_pkg::*;

    int fail_count = 0;  // Read by the testbench at the end

    ////////////////////
    // Interrupts are single-cycle pulses
    a_start_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        irq_start_i |=> !irq_start_i)
        else begin
            $error("interrupt_start_o high for more than one cycle");
            fail_count++;
        end

    a_error_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        irq_error_i |=> !irq_error_i)
        else begin
            $error("interrupt_error_o high for more than one cycle");
            fail_count++;
        end

    ////////////////////
    // Error pulse only together with an idle Halted state
    a_halt_idle: assert property (@(posedge clk) disable iff (!rst_n)
        irq_error_i |-> (state_i == Halted) && !active_i)
        else begin
            $error("interrupt_error_o high without an idle Halted state");
            fail_count++;
        end

    // Stop always lands in Reset
    a_stop_reset: assert property (@(posedge clk) disable iff (!rst_n)
        stop_i |=> state_i == Reset)
        else begin
            $error("FSM not in Reset after stop_i");
            fail_count++;
        end

endmodule

//--- testbench/tb_top.sv
`timescale 1ns/1ns

module tb_top;
    import seq_pkg::*;

    localparam int PC_W  = 10;
    localparam int DEPTH = 1 << PC_W;

    logic            clk;
    logic            rst_n;
    logic            start;
    logic            stop;
    logic [PC_W-1:0] mem_addr;
    word_t           mem_rdata = '0;
    word_t           pulse;
    offset_t         tx_offset;
    offset_t         grad_offset;
    logic            irq_start;
    logic            irq_error;
    logic            active;
    error_code_e     error_code;

    word_t       mem [DEPTH];       // Program in the lower half, data above
    logic [31:0] rng_state = 32'h53b34bca;
    word_t       model_regs [NUM_REGS];
    word_t       exp_pulses [$];
    offset_t     exp_tx;
    offset_t     exp_grad;
    error_code_e exp_error;

    tb_clock #(.PERIOD_NS(100)) u_clock (.clk_o(clk));

    seq_top #(.PC_W(PC_W)) dut0 (
        .clk               (clk),
        .rst_n             (rst_n),
        .start_i           (start),
        .stop_i            (stop),
        .mem_addr_o        (mem_addr),
        .mem_rdata_i       (mem_rdata),
        .tx_offset_o       (tx_offset),
        .grad_offset_o     (grad_offset),
        .pulse_o           (pulse),
        .interrupt_start_o (irq_start),
        .interrupt_error_o (irq_error),
        .error_code_o      (error_code),
        .active_o          (active)
    );

    bind seq_control seq_assert u_assert (
        .clk         (clk),
        .rst_n       (rst_n),
        .stop_i      (stop_i),
        .state_i     (state_q),
        .active_i    (active_o),
        .irq_start_i (interrupt_start_o),
        .irq_error_i (interrupt_error_o)
    );

    always @(posedge clk) begin
        mem_rdata <= mem[mem_addr];  // Block RAM with one cycle of latency
    end

    ////////////////////
    // Helpers
    function automatic logic [31:0] next_rand();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    // ra shares bits 36:32 with the immediate
    function automatic word_t encode(opcode_e op, int ra, int rb, logic [39:0] imm);
        word_t w;
        w = '0;
        w[63:58] = op;
        w[39:0]  = imm;
        w[44:40] = rb[4:0];
        w[36:32] = ra[4:0];
        return w;
    endfunction

    function automatic word_t rand_instr();
        logic [31:0] r;
        r = next_rand();
        case (r % 7)
            0: return encode(LD64, r[12:8], 0, 40'({1'b1, r[24:16]}));
            1: return encode(INC, r[12:8], 0, '0);
            2: return encode(DEC, r[12:8], 0, '0);
            3: return encode(TXOFFSET, 0, 0, 40'(r[31:16]));
            4: return encode(GRADOFFSET, 0, 0, 40'(r[31:16]));
            5: return encode(PR, 0, r[12:8], 40'(r[2:0]));
            default: return encode(NOP, 0, 0, 40'(r[2:0]));
        endcase
    endfunction

    task automatic check_value(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    endtask

    task automatic report_failure(input string what);
        $display("Error at %0t ns: %s", $time, what);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic step();
        @(posedge clk);
        #10;
    endtask

    ////////////////////
    // Program generator, optional register preload and bad last opcode
    task automatic gen_program(input bit init_regs, input bit bad_end);
        int p, n, j_at, l_at, cnt_addr;
        p = 0;
        for (int a = DEPTH / 2; a < DEPTH; a++) begin
            mem[a] = {next_rand(), next_rand()};
        end
        if (init_regs) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                mem[p] = encode(LD64, r, 0, 40'(DEPTH / 2 + r));
                p++;
            end
        end
        n        = 20 + int'(next_rand() % 21);
        j_at     = int'(next_rand() % n);
        l_at     = int'(next_rand() % n);
        if (l_at == j_at) l_at = (j_at + 1) % n;
        cnt_addr = DEPTH / 2 + 100 + int'(next_rand() % 100);
        mem[cnt_addr] = word_t'(1 + next_rand() % 4);  // Loop count 1 to 4
        for (int i = 0; i < n; i++) begin
            if (i == l_at) begin
                mem[p]     = encode(LD64, 31, 0, 40'(cnt_addr));
                mem[p + 1] = encode(DEC, 31, 0, '0);
                mem[p + 2] = encode(PR, 0, 31, 40'(next_rand() % 3));
                mem[p + 3] = encode(JNZ, 31, 0, 40'(p + 1));  // Back to DEC
                p += 4;
            end else if (i == j_at) begin
                mem[p]     = encode(J, 0, 0, 40'(p + 3));  // Skip two words
                mem[p + 1] = rand_instr();
                mem[p + 2] = rand_instr();
                p += 3;
            end else begin
                mem[p] = rand_instr();
                p++;
            end
        end
        mem[p] = bad_end ? encode(opcode_e'(6'h3F), 0, 0, '0) : encode(HALT, 0, 0, '0);
    endtask

    // Instruction level reference, pulse list starts from the armed value 0
    task automatic run_model();
        word_t w;
        word_t last;
        int    pc, steps;
        bit    done;
        last      = '0;
        pc        = 0;
        steps     = 0;
        done      = 1'b0;
        exp_tx    = '0;
        exp_grad  = '0;
        exp_error = Valid;
        exp_pulses.delete();
        while (!done) begin
            w  = mem[pc];
            pc = (pc + 1) % DEPTH;
            case (w[63:58])
                LD64:       model_regs[w[36:32]] = mem[w[PC_W-1:0]];
                INC:        model_regs[w[36:32]] += 64'd1;
                DEC:        model_regs[w[36:32]] -= 64'd1;
                TXOFFSET:   exp_tx = w[15:0];
                GRADOFFSET: exp_grad = w[15:0];
                J:          pc = int'(w[PC_W-1:0]);
                JNZ:        if (model_regs[w[36:32]] != '0) pc = int'(w[PC_W-1:0]);
                NOP: ;
                PR: begin
                    if (model_regs[w[44:40]] != last) exp_pulses.push_back(model_regs[w[44:40]]);
                    last = model_regs[w[44:40]];
                end
                HALT: done = 1'b1;
                default: begin
                    exp_error = InvalidOpcode;
                    done      = 1'b1;
                end
            endcase
            steps++;
            if (steps > 5000) report_failure("reference model never reached the end of the program");
        end
    endtask

    ////////////////////
    // Stimulus sequences
    task automatic apply_reset();
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        #10;
        rst_n = 1'b1;
        foreach (model_regs[i]) model_regs[i] = '0;
    endtask

    task automatic check_idle();
        check_value("pulse_o", pulse, PULSE_IDLE);
        check_value("tx_offset_o", word_t'(tx_offset), '0);
        check_value("grad_offset_o", word_t'(grad_offset), '0);
        check_value("active_o", word_t'(active), '0);
        check_value("interrupt_start_o", word_t'(irq_start), '0);
        check_value("interrupt_error_o", word_t'(irq_error), '0);
    endtask

    task automatic start_run();
        start = 1'b1;
        step();
        start = 1'b0;
        check_value("interrupt_start_o", word_t'(irq_start), 64'd1);
        check_value("active_o", word_t'(active), 64'd1);
        check_value("pulse_o", pulse, '0);  // Armed
        step();
        check_value("interrupt_start_o", word_t'(irq_start), '0);
    endtask

    task automatic run_to_end();
        word_t prev;
        int    idx, cycles;
        prev   = '0;
        idx    = 0;
        cycles = 0;
        while (active) begin
            step();
            cycles++;
            if (pulse !== prev) begin
                if (idx >= exp_pulses.size()) report_failure("pulse_o changed more often than expected");
                check_value("pulse_o", pulse, exp_pulses[idx]);
                idx++;
                prev = pulse;
            end
            if (cycles > 20000) report_failure("timeout while waiting for the sequencer to halt");
        end
        check_value("interrupt_error_o", word_t'(irq_error), 64'd1);
        check_value("error_code_o", word_t'(error_code), word_t'(exp_error));
        check_value("tx_offset_o", word_t'(tx_offset), word_t'(exp_tx));
        check_value("grad_offset_o", word_t'(grad_offset), word_t'(exp_grad));
        check_value("pulse change count", word_t'(idx), word_t'(exp_pulses.size()));
        step();
        check_value("interrupt_error_o", word_t'(irq_error), '0);
    endtask

    task automatic pulse_stop();
        stop = 1'b1;
        step();
        stop = 1'b0;
        check_idle();
    endtask

    initial begin
        rst_n = 1'b0;
        start = 1'b0;
        stop  = 1'b0;
        apply_reset();
        check_idle();
        check_value("error_code_o", word_t'(error_code), word_t'(Valid));

        for (int k = 0; k < 4; k++) begin
            gen_program(k == 0, 1'b0);
            run_model();
            start_run();
            run_to_end();
            pulse_stop();
        end

        gen_program(1'b0, 1'b1);  // Ends on an unknown opcode
        run_model();
        start_run();
        run_to_end();
        pulse_stop();

        // Stop in the middle of a run, then a fresh program
        gen_program(1'b0, 1'b0);
        start_run();
        for (int c = 0; c < 100; c++) begin
            step();
        end
        check_value("active_o", word_t'(active), 64'd1);
        pulse_stop();
        gen_program(1'b1, 1'b0);
        run_model();
        start_run();
        run_to_end();
        pulse_stop();

        if (dut0.u_control.u_assert.fail_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- src.f
source/seq_pkg.sv
source/seq_regfile.sv
source/seq_control.sv
source/seq_out_regs.sv
source/seq_top.sv
testbench/tb_clock.sv
testbench/seq_assert.sv
testbench/tb_top.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the sequencer testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f src.f -o tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "SIMULATION FAILED" "$LOG"; then
    echo "Testbench reported a failure"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi
if ! grep -q "SIMULATION PASSED" "$LOG"; then
    echo "No pass line in $LOG"
    exit 1
fi
exit 0
